// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_streamer
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== compile.f ====
streamer_pkg.sv
stream_addr_counter.sv
stream_fifo.sv
ldst_arbiter_fsm.sv
streamer.sv
streamer_assertions.sv
tb_streamer.sv

// ==== ldst_arbiter_fsm.sv ====
// Memory port arbiter FSM that grants one channel per request and routes read responses back
`timescale 1ns/1ps
`default_nettype none

module ldst_arbiter_fsm #(
  parameter int unsigned AW         = 16,
  parameter int unsigned DW         = 32,
  parameter int unsigned LOAD_DEPTH = streamer_pkg::LOAD_DEPTH
) (
  input  logic                                 clk_i,
  input  logic                                 rst_n_i,
  input  logic                                 clear_i,
  input  logic                                 start_i,
  input  logic [streamer_pkg::NUM_CHAN-1:0]    chan_done_i,
  input  logic [streamer_pkg::NUM_LOAD-1:0][$clog2(LOAD_DEPTH+1)-1:0] load_level_i,
  input  logic [AW-1:0]                        x_addr_i,
  input  logic [AW-1:0]                        w_addr_i,
  input  logic [AW-1:0]                        y_addr_i,
  input  logic [AW-1:0]                        z_addr_i,
  input  logic                                 store_valid_i,
  input  logic [DW-1:0]                        store_data_i,
  output logic [streamer_pkg::NUM_CHAN-1:0]    step_o,
  output logic                                 store_pop_o,
  output logic                                 mem_req_o,
  output logic                                 mem_we_o,
  output logic [AW-1:0]                        mem_add_o,
  output logic [DW-1:0]                        mem_wdata_o,
  input  logic                                 mem_gnt_i,
  input  logic                                 mem_rvalid_i,
  output logic [streamer_pkg::NUM_LOAD-1:0]    load_push_o,
  output logic                                 done_o
);
  import streamer_pkg::*;

  localparam int unsigned LVW = $clog2(LOAD_DEPTH + 1);

  state_t              state_q;
  state_t              state_d;
  logic                done_q;
  logic [NUM_CHAN-1:0] elig;
  logic                sel_found;
  chan_id_t            sel_id;
  // Last granted load channel
  chan_id_t            rr_q;
  // Request held while waiting for a grant
  logic                lock_q;
  chan_id_t            lock_id_q;
  // Read granted last cycle and its owner
  logic                rd_pend_q;
  chan_id_t            rd_chan_q;
  logic                gnt;
  logic                rd_gnt;

  // Load channel eligible while FIFO level plus in-flight read leaves room
  always_comb begin
    logic [LVW:0] used;
    used = '0;
    for (int c = 0; c < NUM_LOAD; c++) begin
      used    = (LVW+1)'(load_level_i[c]) +
                (LVW+1)'(rd_pend_q && (rd_chan_q == chan_id_t'(c)));
      elig[c] = !chan_done_i[c] && (used < (LVW+1)'(LOAD_DEPTH));
    end
    // Store needs a word waiting in its FIFO
    elig[Z_ID] = !chan_done_i[Z_ID] && store_valid_i;
  end

  // Channel select
  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_id    = Z_ID;
    cand      = 0;
    if (lock_q) begin
      // Keep the waiting request unchanged
      sel_found = 1'b1;
      sel_id    = lock_id_q;
    end else if (elig[Z_ID]) begin
      // Store drains first
      sel_found = 1'b1;
      sel_id    = Z_ID;
    end else begin
      // Round robin over loads, starting after the last winner
      for (int i = 1; i <= NUM_LOAD; i++) begin
        cand = rr_q + i;
        if (cand >= NUM_LOAD) begin
          cand = cand - NUM_LOAD;
        end
        if (!sel_found && elig[cand]) begin
          sel_found = 1'b1;
          sel_id    = chan_id_t'(cand);
        end
      end
    end
  end

  // Memory request fields
  assign mem_req_o   = (state_q == RUN) && sel_found;
  assign mem_we_o    = mem_req_o && (sel_id == Z_ID);
  assign mem_wdata_o = store_data_i;

  always_comb begin
    case (sel_id)
      X_ID:    mem_add_o = x_addr_i;
      W_ID:    mem_add_o = w_addr_i;
      Y_ID:    mem_add_o = y_addr_i;
      default: mem_add_o = z_addr_i;
    endcase
  end

  assign gnt    = mem_req_o && mem_gnt_i;
  assign rd_gnt = gnt && !mem_we_o;

  // Counter steps on grant, store word leaves its FIFO on the same edge
  always_comb begin
    step_o = '0;
    if (gnt) begin
      step_o[sel_id] = 1'b1;
    end
  end
  assign store_pop_o = step_o[Z_ID];

  // Response goes to the FIFO of the channel that issued the read
  always_comb begin
    for (int c = 0; c < NUM_LOAD; c++) begin
      load_push_o[c] = mem_rvalid_i && rd_pend_q && (rd_chan_q == chan_id_t'(c));
    end
  end

  // FSM next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      RUN:     if (&chan_done_i) state_d = DRAIN;
      // Wait for the last read response
      DRAIN:   if (!rd_pend_q) state_d = IDLE;
      default: state_d = IDLE;
    endcase
    // New job restarts the FSM
    if (start_i) begin
      state_d = RUN;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      state_q   <= IDLE;
      done_q    <= 1'b0;
      rr_q      <= Y_ID;
      lock_q    <= 1'b0;
      lock_id_q <= X_ID;
      rd_pend_q <= 1'b0;
      rd_chan_q <= X_ID;
    end else begin
      state_q <= state_d;
      if (start_i) begin
        done_q <= 1'b0;
      end else if (state_q == DRAIN && state_d == IDLE) begin
        done_q <= 1'b1;
      end
      if (start_i) begin
        // X gets the first load grant of a job
        lock_q <= 1'b0;
        rr_q   <= Y_ID;
      end else begin
        lock_q <= mem_req_o && !mem_gnt_i;
        if (mem_req_o) lock_id_q <= sel_id;
        if (rd_gnt) rr_q <= sel_id;
      end
      rd_pend_q <= rd_gnt;
      if (rd_gnt) begin
        rd_chan_q <= sel_id;
      end
    end
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== stream_addr_counter.sv ====
// Per-channel word counter and byte-address generator, loaded by the start pulse of a job
`timescale 1ns/1ps
`default_nettype none

module stream_addr_counter #(
  parameter int unsigned AW = 16,
  parameter int unsigned LW = 8
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  input  logic          start_i,
  input  logic [AW-1:0] base_i,
  input  logic [LW-1:0] len_i,
  input  logic          step_i,
  output logic [AW-1:0] addr_o,
  output logic          done_o
);
  import streamer_pkg::*;

  // Current word address
  logic [AW-1:0] addr_q;
  // Words requested by this job
  logic [LW-1:0] len_q;
  // Words issued so far
  logic [LW-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      addr_q <= '0;
      len_q  <= '0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      addr_q <= '0;
      len_q  <= '0;
      cnt_q  <= '0;
    end else if (start_i) begin
      // New job, restart from the base
      addr_q <= base_i;
      len_q  <= len_i;
      cnt_q  <= '0;
    end else if (step_i && !done_o) begin
      // One word granted, move to the next one
      addr_q <= addr_q + AW'(WORD_BYTES);
      cnt_q  <= cnt_q + LW'(1);
    end
  end

  assign addr_o = addr_q;

  // Count equals length
  // Also true after reset, both being zero
  assign done_o = (cnt_q == len_q);

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
// Registered valid/ready FIFO, used as the load stream buffers and the store stream buffer
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int unsigned DW    = 32,
  parameter int unsigned DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       clear_i,
  input  logic                       push_valid_i,
  input  logic [DW-1:0]              push_data_i,
  output logic                       push_ready_o,
  output logic                       pop_valid_o,
  output logic [DW-1:0]              pop_data_o,
  input  logic                       pop_ready_i,
  output logic [$clog2(DEPTH+1)-1:0] level_o
);

  // Pointer width, at least one bit
  localparam int unsigned PW  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned LVW = $clog2(DEPTH + 1);

  // Storage array
  logic [DW-1:0] mem_q [DEPTH];

  logic [PW-1:0]  wr_ptr_q;
  logic [PW-1:0]  rd_ptr_q;
  logic [LVW-1:0] count_q;
  logic [LVW-1:0] count_d;
  logic           full_q;
  logic           empty_q;
  logic           push;
  logic           pop;

  // Handshakes on both sides
  assign push = push_valid_i && !full_q;
  assign pop  = pop_ready_i && !empty_q;

  // Next occupancy
  always_comb begin
    count_d = count_q;
    case ({push, pop})
      2'b10:   count_d = count_q + LVW'(1);
      2'b01:   count_d = count_q - LVW'(1);
      default: count_d = count_q;
    endcase
  end

  // Pointers, occupancy and registered flags
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end else begin
      if (push) begin
        // Wrap at the last slot
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + PW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + PW'(1);
      end
      count_q <= count_d;
      full_q  <= (count_d == LVW'(DEPTH));
      empty_q <= (count_d == '0);
    end
  end

  // Write port
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign push_ready_o = !full_q;
  assign pop_valid_o  = !empty_q;
  // Head of the queue
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign level_o      = count_q;

endmodule

`default_nettype wire

// ==== streamer.sv ====
// Memory streamer top level connecting address counters, stream FIFOs and the arbiter
`timescale 1ns/1ps
`default_nettype none

module streamer #(
  parameter int unsigned DW = 32,
  parameter int unsigned AW = 16,
  parameter int unsigned LW = 8
) (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  // Job control
  input  logic          start_i,
  input  logic [AW-1:0] x_base_i,
  input  logic [AW-1:0] w_base_i,
  input  logic [AW-1:0] y_base_i,
  input  logic [AW-1:0] z_base_i,
  input  logic [LW-1:0] len_i,
  output logic          done_o,
  // X load stream
  output logic          x_valid_o,
  output logic [DW-1:0] x_data_o,
  input  logic          x_ready_i,
  // W load stream
  output logic          w_valid_o,
  output logic [DW-1:0] w_data_o,
  input  logic          w_ready_i,
  // Y load stream
  output logic          y_valid_o,
  output logic [DW-1:0] y_data_o,
  input  logic          y_ready_i,
  // Z store stream
  input  logic          z_valid_i,
  input  logic [DW-1:0] z_data_i,
  output logic          z_ready_o,
  // Memory port
  output logic          mem_req_o,
  output logic          mem_we_o,
  output logic [AW-1:0] mem_add_o,
  output logic [DW-1:0] mem_wdata_o,
  input  logic          mem_gnt_i,
  input  logic [DW-1:0] mem_rdata_i,
  input  logic          mem_rvalid_i
);
  import streamer_pkg::*;

  localparam int unsigned LVW = $clog2(LOAD_DEPTH + 1);

  // Counter side, indexed by channel id
  logic [NUM_CHAN-1:0][AW-1:0]  base;
  logic [NUM_CHAN-1:0][AW-1:0]  addr;
  logic [NUM_CHAN-1:0]          step;
  logic [NUM_CHAN-1:0]          chan_done;
  // Load FIFO side
  logic [NUM_LOAD-1:0]          load_push;
  logic [NUM_LOAD-1:0][LVW-1:0] load_level;
  logic [NUM_LOAD-1:0]          load_valid;
  logic [NUM_LOAD-1:0][DW-1:0]  load_data;
  logic [NUM_LOAD-1:0]          load_ready;
  // Store FIFO head
  logic                         store_valid;
  logic [DW-1:0]                store_data;
  logic                         store_pop;

  // Base addresses by channel
  assign base[X_ID] = x_base_i;
  assign base[W_ID] = w_base_i;
  assign base[Y_ID] = y_base_i;
  assign base[Z_ID] = z_base_i;

  // Load streams out
  assign x_valid_o        = load_valid[X_ID];
  assign x_data_o         = load_data[X_ID];
  assign load_ready[X_ID] = x_ready_i;
  assign w_valid_o        = load_valid[W_ID];
  assign w_data_o         = load_data[W_ID];
  assign load_ready[W_ID] = w_ready_i;
  assign y_valid_o        = load_valid[Y_ID];
  assign y_data_o         = load_data[Y_ID];
  assign load_ready[Y_ID] = y_ready_i;

  // One address counter per channel
  for (genvar c = 0; c < NUM_CHAN; c++) begin : gen_counter
    stream_addr_counter #(
      .AW ( AW ),
      .LW ( LW )
    ) i_counter (
      .clk_i   ( clk_i        ),
      .rst_n_i ( rst_n_i      ),
      .clear_i ( clear_i      ),
      .start_i ( start_i      ),
      .base_i  ( base[c]      ),
      .len_i   ( len_i        ),
      .step_i  ( step[c]      ),
      .addr_o  ( addr[c]      ),
      .done_o  ( chan_done[c] )
    );
  end

  // Load buffers share the read data bus
  // Room is guaranteed by the arbiter credit, so push ready stays open
  for (genvar c = 0; c < NUM_LOAD; c++) begin : gen_load_fifo
    stream_fifo #(
      .DW    ( DW         ),
      .DEPTH ( LOAD_DEPTH )
    ) i_load_fifo (
      .clk_i        ( clk_i         ),
      .rst_n_i      ( rst_n_i       ),
      .clear_i      ( clear_i       ),
      .push_valid_i ( load_push[c]  ),
      .push_data_i  ( mem_rdata_i   ),
      .push_ready_o (               ),
      .pop_valid_o  ( load_valid[c] ),
      .pop_data_o   ( load_data[c]  ),
      .pop_ready_i  ( load_ready[c] ),
      .level_o      ( load_level[c] )
    );
  end

  // Store buffer between Z stream and memory writes
  stream_fifo #(
    .DW    ( DW          ),
    .DEPTH ( STORE_DEPTH )
  ) i_store_fifo (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .clear_i      ( clear_i     ),
    .push_valid_i ( z_valid_i   ),
    .push_data_i  ( z_data_i    ),
    .push_ready_o ( z_ready_o   ),
    .pop_valid_o  ( store_valid ),
    .pop_data_o   ( store_data  ),
    .pop_ready_i  ( store_pop   ),
    .level_o      (             )
  );

  // Memory port arbiter
  ldst_arbiter_fsm #(
    .AW         ( AW         ),
    .DW         ( DW         ),
    .LOAD_DEPTH ( LOAD_DEPTH )
  ) i_arbiter (
    .clk_i         ( clk_i        ),
    .rst_n_i       ( rst_n_i      ),
    .clear_i       ( clear_i      ),
    .start_i       ( start_i      ),
    .chan_done_i   ( chan_done    ),
    .load_level_i  ( load_level   ),
    .x_addr_i      ( addr[X_ID]   ),
    .w_addr_i      ( addr[W_ID]   ),
    .y_addr_i      ( addr[Y_ID]   ),
    .z_addr_i      ( addr[Z_ID]   ),
    .store_valid_i ( store_valid  ),
    .store_data_i  ( store_data   ),
    .step_o        ( step         ),
    .store_pop_o   ( store_pop    ),
    .mem_req_o     ( mem_req_o    ),
    .mem_we_o      ( mem_we_o     ),
    .mem_add_o     ( mem_add_o    ),
    .mem_wdata_o   ( mem_wdata_o  ),
    .mem_gnt_i     ( mem_gnt_i    ),
    .mem_rvalid_i  ( mem_rvalid_i ),
    .load_push_o   ( load_push    ),
    .done_o        ( done_o       )
  );

endmodule

`default_nettype wire

// ==== streamer_assertions.sv ====
// Concurrent stream and memory protocol checks, bound into the streamer top level
`timescale 1ns/1ps
`default_nettype none

module streamer_assertions #(
  parameter int unsigned DW = 32,
  parameter int unsigned AW = 16
) (
  input logic                 clk_i,
  input logic                 rst_n_i,
  input logic                 clear_i,
  input logic                 x_valid_o,
  input logic [DW-1:0]        x_data_o,
  input logic                 x_ready_i,
  input logic                 w_valid_o,
  input logic [DW-1:0]        w_data_o,
  input logic                 w_ready_i,
  input logic                 y_valid_o,
  input logic [DW-1:0]        y_data_o,
  input logic                 y_ready_i,
  input logic                 mem_req_o,
  input logic                 mem_we_o,
  input logic [AW-1:0]        mem_add_o,
  input logic [DW-1:0]        mem_wdata_o,
  input logic                 mem_gnt_i,
  input logic                 done_o,
  input streamer_pkg::state_t arb_state_i
);
  import streamer_pkg::*;

  // Number of failed properties
  int fail_cnt = 0;

  // Load words hold while the consumer stalls
  assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    x_valid_o && !x_ready_i |=> x_valid_o && $stable(x_data_o))
    else begin
      fail_cnt++;
      $error("X stream changed valid or data while stalled");
    end
  assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o))
    else begin
      fail_cnt++;
      $error("W stream changed valid or data while stalled");
    end
  assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    y_valid_o && !y_ready_i |=> y_valid_o && $stable(y_data_o))
    else begin
      fail_cnt++;
      $error("Y stream changed valid or data while stalled");
    end

  // Waiting request keeps its fields, write data only matters for writes
  assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_add_o) && $stable(mem_we_o)
      && (!mem_we_o || $stable(mem_wdata_o)))
    else begin
      fail_cnt++;
      $error("Memory request changed before its grant");
    end

  // Finished job issues nothing
  assert property (@(posedge clk_i) disable iff (!rst_n_i || clear_i)
    done_o |-> !mem_req_o && arb_state_i == IDLE)
    else begin
      fail_cnt++;
      $error("Request or busy arbiter while done is high");
    end

endmodule

bind streamer streamer_assertions #(
  .DW ( DW ),
  .AW ( AW )
) i_assertions (
  .*,
  .arb_state_i ( i_arbiter.state_q )
);

`default_nettype wire

// ==== streamer_pkg.sv ====
// Shared channel indices, depths and arbiter states, imported by every streamer RTL block
`default_nettype none

package streamer_pkg;

  // Three load channels and one store channel
  localparam int unsigned NUM_CHAN = 4;
  localparam int unsigned NUM_LOAD = 3;

  // Channel index, wide enough for all four channels
  typedef logic [1:0] chan_id_t;

  // Channel indices into counters and arbiter vectors
  localparam chan_id_t X_ID = 2'd0;
  localparam chan_id_t W_ID = 2'd1;
  localparam chan_id_t Y_ID = 2'd2;
  // Store channel sits above the load channels
  localparam chan_id_t Z_ID = 2'd3;

  // Byte distance between consecutive memory words
  localparam int unsigned WORD_BYTES = 4;

  // Default FIFO depths passed down by the top level
  localparam int unsigned LOAD_DEPTH  = 4;
  localparam int unsigned STORE_DEPTH = 2;

  // Arbiter FSM states
  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DRAIN
  } state_t;

endpackage

`default_nettype wire

// ==== tb_streamer.sv ====
// Testbench for the streamer with memory model, random stalls, scoreboard checks and a timeout
`timescale 1ns/1ps
`default_nettype none

module tb_streamer;
  import streamer_pkg::*;

  localparam int unsigned DW       = 32;
  localparam int unsigned AW       = 16;
  localparam int unsigned LW       = 8;
  localparam int unsigned LEN      = 12;
  localparam int unsigned NUM_JOBS = 2;
  // Worst slowdown from random grants and stalled readies
  localparam int unsigned STALL      = 16;
  localparam int unsigned MAX_CYCLES = NUM_JOBS * (LEN * NUM_CHAN * STALL + 100);

  logic          clk_i;
  logic          rst_n_i;
  logic          clear_i;
  logic          start_i;
  logic [AW-1:0] x_base_i;
  logic [AW-1:0] w_base_i;
  logic [AW-1:0] y_base_i;
  logic [AW-1:0] z_base_i;
  logic [LW-1:0] len_i;
  logic          done_o;
  logic          x_valid_o;
  logic [DW-1:0] x_data_o;
  logic          x_ready_i;
  logic          w_valid_o;
  logic [DW-1:0] w_data_o;
  logic          w_ready_i;
  logic          y_valid_o;
  logic [DW-1:0] y_data_o;
  logic          y_ready_i;
  logic          z_valid_i;
  logic [DW-1:0] z_data_i;
  logic          z_ready_o;
  logic          mem_req_o;
  logic          mem_we_o;
  logic [AW-1:0] mem_add_o;
  logic [DW-1:0] mem_wdata_o;
  logic          mem_gnt_i;
  logic [DW-1:0] mem_rdata_i;
  logic          mem_rvalid_i;

  // Load stream views indexed by channel id
  logic [2:0]    rdy;
  logic [2:0]    ld_vld;
  logic [DW-1:0] ld_data [3];
  logic [AW-1:0] ld_base [3];
  int            ld_cnt  [3];
  // Memory model, one entry per word address
  logic [DW-1:0] wmem [2**(AW-2)];
  logic [DW-1:0] zq [$];
  // Z word handed over on the coming rising edge
  logic          z_taken;
  logic          rd_fire;
  logic [AW-1:0] rd_addr;
  logic          done_seen;
  int            rd_grants;
  int            wr_grants;
  int            z_sent;
  int            done_rises;
  int            checks;
  int            errors;
  int            cycles;

  assign x_ready_i = rdy[0];
  assign w_ready_i = rdy[1];
  assign y_ready_i = rdy[2];
  assign ld_vld     = {y_valid_o, w_valid_o, x_valid_o};
  assign ld_data[0] = x_data_o;
  assign ld_data[1] = w_data_o;
  assign ld_data[2] = y_data_o;

  streamer #(
    .DW ( DW ),
    .AW ( AW ),
    .LW ( LW )
  ) streamer_i (.*);

  always #4 clk_i = ~clk_i;

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Memory port, stream traffic and done tracking, all driven on the falling edge
  always @(negedge clk_i) begin
    logic [AW-1:0] a;
    if (rst_n_i) begin
      // Response for the read granted on the last rising edge
      mem_rvalid_i = rd_fire;
      mem_rdata_i  = rd_fire ? (DW'(rd_addr) ^ 32'hA5A5_0000) : '0;
      mem_gnt_i    = ($urandom_range(3) != 0);
      // Request is stable here, so this is the handshake of the next edge
      rd_fire = mem_req_o && mem_gnt_i && !mem_we_o;
      rd_addr = mem_add_o;
      if (rd_fire) rd_grants++;
      if (mem_req_o && mem_gnt_i && mem_we_o) begin
        wmem[mem_add_o[AW-1:2]] = mem_wdata_o;
        wr_grants++;
      end
      for (int c = 0; c < 3; c++) begin
        // Rare flips give long stall stretches
        if ($urandom_range(7) == 0) rdy[c] = !rdy[c];
        if (ld_vld[c] && rdy[c]) begin
          assert (ld_cnt[c] < LEN) else begin
            errors++;
            $display("Load stream %0d delivered more than %0d words", c, LEN);
          end
          a = ld_base[c] + AW'(ld_cnt[c] * WORD_BYTES);
          check_value("load_order", DW'(a) ^ 32'hA5A5_0000, ld_data[c]);
          ld_cnt[c]++;
        end
      end
      // Z word taken on the last rising edge leaves the bus
      if (z_taken) z_valid_i = 1'b0;
      // Store stream, new word only after the last one transferred
      if (!z_valid_i && z_sent < LEN && $urandom_range(3) != 0) begin
        z_valid_i = 1'b1;
        z_data_i  = $urandom;
      end
      z_taken = z_valid_i && z_ready_o;
      if (z_taken) begin
        zq.push_back(z_data_i);
        z_sent++;
      end
      if (done_o && !done_seen) done_rises++;
      done_seen = done_o;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, job did not complete", cycles);
      $display("Checks %0d, errors %0d", checks, errors);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic run_job(input logic [AW-1:0] xb, input logic [AW-1:0] wb,
                         input logic [AW-1:0] yb, input logic [AW-1:0] zb);
    logic [AW-1:0] a;
    @(negedge clk_i);
    ld_base[0] = xb;
    ld_base[1] = wb;
    ld_base[2] = yb;
    ld_cnt     = '{0, 0, 0};
    zq.delete();
    z_sent    = 0;
    rd_grants = 0;
    wr_grants = 0;
    x_base_i  = xb;
    w_base_i  = wb;
    y_base_i  = yb;
    z_base_i  = zb;
    len_i     = LW'(LEN);
    start_i   = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    check_value("done_after_start", 32'd0, 32'(done_o));
    while (!done_o) @(negedge clk_i);
    // Grant counts at the moment done rises
    check_value("read_grants", 3 * LEN, rd_grants);
    check_value("write_grants", LEN, wr_grants);
    // Loads may still sit in their FIFOs
    while (ld_cnt[0] < LEN || ld_cnt[1] < LEN || ld_cnt[2] < LEN) @(negedge clk_i);
    for (int k = 0; k < LEN; k++) begin
      a = zb + AW'(k * WORD_BYTES);
      check_value("store_place", zq[k], wmem[a[AW-1:2]]);
    end
  endtask

  initial begin
    void'($urandom(32'h84eb));
    clk_i      = 1'b0;
    rst_n_i    = 1'b0;
    clear_i    = 1'b0;
    start_i    = 1'b0;
    x_base_i   = '0;
    w_base_i   = '0;
    y_base_i   = '0;
    z_base_i   = '0;
    len_i      = '0;
    rdy        = '0;
    z_valid_i  = 1'b0;
    z_data_i   = '0;
    z_taken    = 1'b0;
    // Store stream stays quiet until the first job
    z_sent     = LEN;
    mem_gnt_i  = 1'b0;
    mem_rdata_i  = '0;
    mem_rvalid_i = 1'b0;
    rd_fire    = 1'b0;
    rd_addr    = '0;
    done_seen  = 1'b0;
    done_rises = 0;
    checks     = 0;
    errors     = 0;
    cycles     = 0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    // Idle outputs after reset
    check_value("reset_req", 32'd0, 32'(mem_req_o));
    check_value("reset_valid", 32'd0, 32'(ld_vld));
    check_value("reset_done", 32'd0, 32'(done_o));
    check_value("reset_z_ready", 32'd1, 32'(z_ready_o));
    run_job(16'h0100, 16'h0400, 16'h0800, 16'h1000);
    run_job(16'h2000, 16'h2340, 16'h3000, 16'h4100);
    check_value("done_rises", NUM_JOBS, done_rises);
    // Failed protocol properties of the bound checker
    errors += streamer_i.i_assertions.fail_cnt;
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
